/* filelist.f */
+incdir+hw
hw/periph_pkg.sv
hw/periph_decoder.sv
hw/irq_ctrl.sv
hw/rng_fifo.sv
hw/gpio_regs.sv
hw/periph_top.sv
sim/tb_clock.sv
sim/periph_assertions.sv
sim/periph_tb.sv

/* sim/periph_tb.sv */
// ---------------------------------------------------------------------------
// Peripheral block testbench
// Applies a table of bus requests and checks data, error, IRQ and LEDs
// ---------------------------------------------------------------------------

`timescale 1ns/1ns
`include "periph_config.svh"

module periph_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 8;
    localparam int IDLE_CYCLES = 20;

    typedef struct packed {
        logic                      write;
        logic [`PERIPH_ADDR_W-1:0] addr;
        logic [`PERIPH_DATA_W-1:0] wdata;
        periph_pkg::src_vec_t      src;
        logic [7:0]                dip;
        logic [`PERIPH_DATA_W-1:0] exp_rdata;
        logic                      exp_err;
        logic                      exp_irq;
    } entry_t;

    logic                    clk;
    logic                    rst_n;
    periph_pkg::periph_req_t req;
    periph_pkg::periph_rsp_t rsp;
    periph_pkg::src_vec_t    src;
    logic [7:0]              dip;
    logic [7:0]              leds;
    logic                    irq;

    entry_t     entries[$];
    string      names[$];
    logic [7:0] leds_exp = 8'h00;
    bit         table_ready = 1'b0;

    tb_clock #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(RST_CYCLES)) u_clock (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    periph_top uut (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .req_i     (req),
        .rsp_o     (rsp),
        .irq_src_i (src),
        .irq_o     (irq),
        .dip_i     (dip),
        .leds_o    (leds)
    );

    // Reference Galois LFSR, shift right and fold in the mask on a set LSB
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] taps;
        taps = {32{s[0]}} & `PERIPH_RNG_POLY;
        return (s >> 1) ^ taps;
    endfunction

    task automatic add_entry(input string name, input logic wr, input logic [15:0] addr,
                             input logic [31:0] wdata, input logic [3:0] s, input logic [7:0] d,
                             input logic [31:0] rd, input logic err, input logic irq_e);
        entries.push_back('{wr, addr, wdata, s, d, rd, err, irq_e});
        names.push_back(name);
    endtask

    task automatic apply_entry(input int idx, output bit ok);
        entry_t e;
        int     waited;
        e = entries[idx];
        ok = 1'b1;
        waited = 0;
        @(posedge clk);
        req <= '{valid: 1'b1, write: e.write, addr: e.addr, wdata: e.wdata};
        src <= e.src;
        dip <= e.dip;
        @(posedge clk);
        req.valid <= 1'b0;
        if (e.write && e.addr == 16'h1000) leds_exp = e.wdata[7:0];  // LED register
        @(negedge clk);
        while (!rsp.valid && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        assert (rsp.valid) else begin
            $display("Test %s got no response from the DUT", names[idx]);
            ok = 1'b0;
        end
        if (rsp.valid) begin
            assert (rsp.rdata == e.exp_rdata) else begin
                $display("Error %s rdata expected %h actual %h", names[idx], e.exp_rdata,
                         rsp.rdata);
                ok = 1'b0;
            end
            assert (rsp.error == e.exp_err) else begin
                $display("Error %s error expected %b actual %b", names[idx], e.exp_err,
                         rsp.error);
                ok = 1'b0;
            end
        end
        assert (irq == e.exp_irq) else begin
            $display("Error %s irq_o expected %b actual %b", names[idx], e.exp_irq, irq);
            ok = 1'b0;
        end
        assert (leds == leds_exp) else begin
            $display("Error %s leds_o expected %h actual %h", names[idx], leds_exp, leds);
            ok = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------------
    // Table and main loop
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] state;
        logic [7:0]  dip_a;
        logic [7:0]  dip_b;
        bit          ok;
        int          pass_cnt;
        int          fail_cnt;
        req = '0;
        src = '0;
        dip = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        void'($urandom(32'he2b1));
        dip_a = 8'($urandom);
        dip_b = 8'($urandom);
        state = `PERIPH_RNG_SEED;

        add_entry("reset_claim", 0, 16'h0018, 0, 4'h0, 8'h00, 32'h0, 0, 0);
        add_entry("led_write", 1, 16'h1000, 32'h5a, 4'h0, 8'h00, 32'h0, 0, 0);
        add_entry("dip_read_a", 0, 16'h1000, 0, 4'h0, dip_a, {24'h0, dip_a}, 0, 0);
        add_entry("dip_read_b", 0, 16'h1000, 0, 4'h0, dip_b, {24'h0, dip_b}, 0, 0);
        add_entry("spi_read", 0, 16'h2004, 0, 4'h0, 8'h00, 32'hdeadbeef, 1, 0);
        add_entry("eth_write", 1, 16'h3010, 32'h12345678, 4'h0, 8'h00, 32'hdeadbeef, 1, 0);
        add_entry("rng_status", 0, 16'h1018, 0, 4'h0, 8'h00, 32'h8000_0008, 0, 0);  // Full, 8
        for (int i = 0; i < 3; i++) begin
            state = lfsr_step(state);
            add_entry($sformatf("rng_pop_%0d", i), 0, 16'h1010, 0, 4'h0, 8'h00, state, 0, 0);
        end
        add_entry("prio0_write", 1, 16'h0000, 32'd3, 4'h0, 8'h00, 32'h0, 0, 0);
        add_entry("prio1_write", 1, 16'h0004, 32'd5, 4'h0, 8'h00, 32'h0, 0, 0);
        add_entry("prio2_write", 1, 16'h0008, 32'd5, 4'h0, 8'h00, 32'h0, 0, 0);
        add_entry("prio3_write", 1, 16'h000c, 32'd1, 4'h0, 8'h00, 32'h0, 0, 0);
        add_entry("thresh_write", 1, 16'h0014, 32'd2, 4'h0, 8'h00, 32'h0, 0, 0);
        add_entry("src_disabled", 0, 16'h0018, 0, 4'hf, 8'h00, 32'h0, 0, 0);
        add_entry("enable_all", 1, 16'h0010, 32'hf, 4'hf, 8'h00, 32'h0, 0, 0);
        add_entry("claim_tie", 0, 16'h0018, 0, 4'hf, 8'h00, 32'd2, 0, 1);     // 1 and 2 tie
        add_entry("claim_src2", 0, 16'h0018, 0, 4'h5, 8'h00, 32'd3, 0, 1);
        add_entry("below_thresh", 0, 16'h0018, 0, 4'h8, 8'h00, 32'd4, 0, 0);
        add_entry("src_idle", 0, 16'h0018, 0, 4'h0, 8'h00, 32'd0, 0, 0);
        add_entry("irq_rise", 0, 16'h0018, 0, 4'h1, 8'h00, 32'd1, 0, 1);
        add_entry("mask_src0", 1, 16'h0010, 32'he, 4'h1, 8'h00, 32'h0, 0, 1); // Old mask
        add_entry("claim_masked", 0, 16'h0018, 0, 4'h1, 8'h00, 32'd0, 0, 0);
        table_ready = 1'b1;

        wait (rst_n);
        repeat (IDLE_CYCLES) @(posedge clk);   // FIFO fills meanwhile
        foreach (entries[i]) begin
            apply_entry(i, ok);
            if (ok) pass_cnt++;
            else fail_cnt++;
            $display("%s %s", ok ? "ok  " : "FAIL", names[i]);
        end
        $display("Tests: %0d, passed: %0d, failed: %0d, assertion failures: %0d",
                 entries.size(), pass_cnt, fail_cnt, uut.u_assert.fail_count);
        if (fail_cnt == 0 && uut.u_assert.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog, twice the expected run length
    initial begin
        longint limit;
        wait (table_ready);
        limit = longint'(RST_CYCLES + entries.size() * 4 + IDLE_CYCLES) * CLK_PERIOD * 2;
        #(limit);
        $display("Timeout, the run did not finish within %0d ns", limit);
        $display("Checks failed");
        $finish;
    end

endmodule

/* sim/periph_assertions.sv */
// ---------------------------------------------------------------------------
// Bus and interrupt assertions
// Response timing, error flag per region, interrupt gated by the enable mask
// ---------------------------------------------------------------------------

`timescale 1ns/1ns
`include "periph_config.svh"

module periph_assertions (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input periph_pkg::periph_req_t req_i,
    input periph_pkg::periph_rsp_t rsp_i,
    input logic                    irq_i,
    input periph_pkg::src_vec_t    enable_i
);

    int fail_count = 0;                         // Read by the testbench at the end

    // One response per request, in the next cycle
    assert property (@(posedge clk_i) disable iff (!rst_n_i) req_i.valid |=> rsp_i.valid)
        else begin
            $error("Request without a response in the next cycle");
            fail_count++;
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) !req_i.valid |=> !rsp_i.valid)
        else begin
            $error("Response without a request in the cycle before");
            fail_count++;
        end

    // Regions 2 and 3 have the upper region bit set
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
                     req_i.valid |=> rsp_i.error == $past(req_i.addr[`PERIPH_REGION_LSB + 1]))
        else begin
            $error("Error flag does not match the region of the request");
            fail_count++;
        end

    assert property (@(posedge clk_i) disable iff (!rst_n_i) (enable_i == '0) |=> !irq_i)
        else begin
            $error("Interrupt raised with all sources disabled");
            fail_count++;
        end

endmodule

bind periph_top periph_assertions u_assert (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (req_i),
    .rsp_i    (rsp_o),
    .irq_i    (irq_o),
    .enable_i (u_irq.enable_q)
);

/* sim/tb_clock.sv */
// ---------------------------------------------------------------------------
// Testbench clock and reset
// Free running clock and an active low reset held for a number of cycles
// ---------------------------------------------------------------------------

`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;                        // Release on a rising edge
    end

endmodule

/* hw/periph_top.sv */
// ---------------------------------------------------------------------------
// Peripheral block top level
// Decoder with the interrupt controller and the GPIO/RNG slave behind it
// ---------------------------------------------------------------------------

`timescale 1ns/1ns

module periph_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  periph_pkg::periph_req_t req_i,
    output periph_pkg::periph_rsp_t rsp_o,
    input  periph_pkg::src_vec_t    irq_src_i,
    output logic                    irq_o,
    input  logic [7:0]              dip_i,
    output logic [7:0]              leds_o
);

    logic                    irq_sel;
    logic                    gpio_sel;
    periph_pkg::periph_rsp_t irq_rsp;
    periph_pkg::periph_rsp_t gpio_rsp;

    periph_decoder u_decoder (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .irq_rsp_i  (irq_rsp),
        .gpio_rsp_i (gpio_rsp),
        .irq_sel_o  (irq_sel),
        .gpio_sel_o (gpio_sel),
        .rsp_o      (rsp_o)
    );

    irq_ctrl u_irq (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .sel_i     (irq_sel),
        .req_i     (req_i),
        .irq_src_i (irq_src_i),
        .rsp_o     (irq_rsp),
        .irq_o     (irq_o)
    );

    gpio_regs u_gpio (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .sel_i   (gpio_sel),
        .req_i   (req_i),
        .dip_i   (dip_i),
        .leds_o  (leds_o),
        .rsp_o   (gpio_rsp)
    );

endmodule

/* hw/gpio_regs.sv */
// ---------------------------------------------------------------------------
// GPIO and RNG registers
// LED output, DIP switch readback, random word pop and FIFO status
// ---------------------------------------------------------------------------

`timescale 1ns/1ns
`include "periph_config.svh"

module gpio_regs (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    sel_i,
    input  periph_pkg::periph_req_t req_i,
    input  logic [7:0]              dip_i,
    output logic [7:0]              leds_o,
    output periph_pkg::periph_rsp_t rsp_o
);

    // Offsets decoded on addr[4:3]
    localparam logic [1:0] OFS_LED    = 2'b00;  // 0x00
    localparam logic [1:0] OFS_RNG    = 2'b10;  // 0x10
    localparam logic [1:0] OFS_STATUS = 2'b11;  // 0x18

    logic [1:0]                ofs;
    logic [7:0]                leds_q;
    logic                      rng_pop;
    logic [31:0]               rng_data;
    logic [3:0]                rng_count;
    logic                      rng_full;
    logic                      rng_empty;
    logic [`PERIPH_DATA_W-1:0] rdata_d;
    logic [`PERIPH_DATA_W-1:0] rdata_q;
    logic                      rsp_valid_q;

    assign ofs     = req_i.addr[4:3];
    assign rng_pop = sel_i && !req_i.write && (ofs == OFS_RNG) && !rng_empty;

    rng_fifo u_rng (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .pop_i   (rng_pop),
        .data_o  (rng_data),
        .count_o (rng_count),
        .full_o  (rng_full),
        .empty_o (rng_empty)
    );

    always_comb begin
        rdata_d = '0;
        if (!req_i.write) begin
            case (ofs)
                OFS_LED:    rdata_d = {{(`PERIPH_DATA_W-8){1'b0}}, dip_i};
                OFS_RNG:    rdata_d = rng_data;  // Head word, popped in the same cycle
                OFS_STATUS: rdata_d = {rng_full, rng_empty, {(`PERIPH_DATA_W-6){1'b0}}, rng_count};
                default:    rdata_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            leds_q      <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= sel_i;
            if (sel_i && req_i.write && (ofs == OFS_LED)) leds_q <= req_i.wdata[7:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (sel_i) rdata_q <= rdata_d;
    end

    assign rsp_o  = '{valid: rsp_valid_q, error: 1'b0, rdata: rdata_q};
    assign leds_o = leds_q;

endmodule

/* hw/rng_fifo.sv */
// ---------------------------------------------------------------------------
// Random number FIFO
// A Galois LFSR fills the FIFO whenever it has room, one word per cycle
// ---------------------------------------------------------------------------

`timescale 1ns/1ns
`include "periph_config.svh"

module rng_fifo (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        pop_i,
    output logic [31:0] data_o,
    output logic [3:0]  count_o,
    output logic        full_o,
    output logic        empty_o
);

    localparam int DEPTH = `PERIPH_RNG_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [`PERIPH_DATA_W-1:0] mem [DEPTH];
    logic [`PERIPH_DATA_W-1:0] lfsr_q;
    logic [`PERIPH_DATA_W-1:0] lfsr_next;
    logic [PTR_W-1:0]          wr_ptr_q;
    logic [PTR_W-1:0]          rd_ptr_q;
    logic [3:0]                count_q;
    logic                      push;
    logic                      pop;

    // Shift right, fold the taps in when the bit shifted out is set
    assign lfsr_next = lfsr_q[0] ? ((lfsr_q >> 1) ^ `PERIPH_RNG_POLY) : (lfsr_q >> 1);

    assign full_o  = (count_q == 4'(DEPTH));
    assign empty_o = (count_q == '0);
    assign push    = !full_o;                   // Keep topped up
    assign pop     = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lfsr_q   <= `PERIPH_RNG_SEED;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                lfsr_q   <= lfsr_next;          // Advance only on push
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + 4'(push) - 4'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) mem[wr_ptr_q] <= lfsr_next;
    end

    assign data_o  = mem[rd_ptr_q];
    assign count_o = count_q;

endmodule

/* hw/irq_ctrl.sv */
// ---------------------------------------------------------------------------
// Level-sensitive priority interrupt controller
// Per-source priority, enable mask and threshold. The claim register names
// the highest priority active source, irq_o flags it above the threshold
// ---------------------------------------------------------------------------

`timescale 1ns/1ns
`include "periph_config.svh"

module irq_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    sel_i,
    input  periph_pkg::periph_req_t req_i,
    input  periph_pkg::src_vec_t    irq_src_i,
    output periph_pkg::periph_rsp_t rsp_o,
    output logic                    irq_o
);

    localparam int NSRC    = `PERIPH_NUM_SRC;
    localparam int PW      = `PERIPH_PRIO_W;
    localparam int IDX_W   = $clog2(NSRC);
    localparam int CLAIM_W = $clog2(NSRC + 1);

    // Word map, priorities first
    localparam logic [2:0] WORD_ENABLE = 3'(NSRC);
    localparam logic [2:0] WORD_THRESH = 3'(NSRC + 1);
    localparam logic [2:0] WORD_CLAIM  = 3'(NSRC + 2);

    logic [PW-1:0]              prio_q [NSRC];
    periph_pkg::src_vec_t       enable_q;
    logic [PW-1:0]              thresh_q;
    logic [2:0]                 word;
    logic [CLAIM_W-1:0]         claim_d;          // Index plus one, 0 if none
    logic [PW-1:0]              win_prio;
    logic [`PERIPH_DATA_W-1:0]  rdata_d;
    logic [`PERIPH_DATA_W-1:0]  rdata_q;
    logic                       rsp_valid_q;
    logic                       irq_q;

    assign word = req_i.addr[4:2];

    // ------------------------------------------------------------------------
    // Claim search, strict compare keeps ties on the lower index
    // ------------------------------------------------------------------------
    always_comb begin
        claim_d  = '0;
        win_prio = '0;                                  // Priority 0 never wins
        for (int i = 0; i < NSRC; i++) begin
            if (irq_src_i[i] && enable_q[i] && (prio_q[i] > win_prio)) begin
                claim_d  = CLAIM_W'(i + 1);
                win_prio = prio_q[i];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NSRC; i++) begin
                prio_q[i] <= '0;
            end
            enable_q <= '0;
            thresh_q <= '0;
            irq_q    <= 1'b0;
        end else begin
            irq_q <= (claim_d != '0) && (win_prio > thresh_q);
            if (sel_i && req_i.write) begin
                if (word < WORD_ENABLE) prio_q[word[IDX_W-1:0]] <= req_i.wdata[PW-1:0];
                else if (word == WORD_ENABLE) enable_q <= req_i.wdata[NSRC-1:0];
                else if (word == WORD_THRESH) thresh_q <= req_i.wdata[PW-1:0];
            end
        end
    end

    // Read mux, writes answer with 0
    always_comb begin
        rdata_d = '0;
        if (!req_i.write) begin
            if (word < WORD_ENABLE) rdata_d[PW-1:0] = prio_q[word[IDX_W-1:0]];
            else if (word == WORD_ENABLE) rdata_d[NSRC-1:0] = enable_q;
            else if (word == WORD_THRESH) rdata_d[PW-1:0] = thresh_q;
            else if (word == WORD_CLAIM) rdata_d[CLAIM_W-1:0] = claim_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) rsp_valid_q <= 1'b0;
        else rsp_valid_q <= sel_i;
    end

    always_ff @(posedge clk_i) begin
        if (sel_i) rdata_q <= rdata_d;
    end

    assign rsp_o = '{valid: rsp_valid_q, error: 1'b0, rdata: rdata_q};
    assign irq_o = irq_q;

endmodule

/* hw/periph_decoder.sv */
// ---------------------------------------------------------------------------
// Address decoder
// Routes requests to the slave of their region, muxes the responses back
// and answers the regions without a peripheral with an error
// ---------------------------------------------------------------------------

`timescale 1ns/1ns
`include "periph_config.svh"

module periph_decoder (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  periph_pkg::periph_req_t req_i,
    input  periph_pkg::periph_rsp_t irq_rsp_i,
    input  periph_pkg::periph_rsp_t gpio_rsp_i,
    output logic                    irq_sel_o,
    output logic                    gpio_sel_o,
    output periph_pkg::periph_rsp_t rsp_o
);

    periph_pkg::region_e region;
    periph_pkg::region_e region_q;   // Region of the request in flight
    logic                valid_q;

    assign region = periph_pkg::region_e'(req_i.addr[`PERIPH_REGION_LSB +: 2]);

    assign irq_sel_o  = req_i.valid && (region == periph_pkg::REGION_IRQ);
    assign gpio_sel_o = req_i.valid && (region == periph_pkg::REGION_GPIO);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q  <= 1'b0;
            region_q <= periph_pkg::REGION_IRQ;
        end else begin
            valid_q <= req_i.valid;
            if (req_i.valid) begin
                region_q <= region;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Response mux
    // ------------------------------------------------------------------------
    always_comb begin
        rsp_o = '0;
        case (region_q)
            periph_pkg::REGION_IRQ:  rsp_o = irq_rsp_i;
            periph_pkg::REGION_GPIO: rsp_o = gpio_rsp_i;
            default: begin                              // No slave, answer here
                rsp_o.valid = valid_q;
                rsp_o.error = 1'b1;
                rsp_o.rdata = `PERIPH_ABSENT_DATA;
            end
        endcase
    end

endmodule

/* hw/periph_pkg.sv */
// ---------------------------------------------------------------------------
// Peripheral block types
// Request and response structs of the register bus, and the address regions
// ---------------------------------------------------------------------------

`include "periph_config.svh"

package periph_pkg;

    // Request from the single bus master, one cycle strobe
    typedef struct packed {
        logic                      valid;
        logic                      write;
        logic [`PERIPH_ADDR_W-1:0] addr;
        logic [`PERIPH_DATA_W-1:0] wdata;
    } periph_req_t;

    // Response, one cycle after the request
    typedef struct packed {
        logic                      valid;
        logic                      error;
        logic [`PERIPH_DATA_W-1:0] rdata;
    } periph_rsp_t;

    // Address regions, SPI and ETH have no peripheral behind them
    typedef enum logic [1:0] {
        REGION_IRQ  = 2'd0,
        REGION_GPIO = 2'd1,
        REGION_SPI  = 2'd2,
        REGION_ETH  = 2'd3
    } region_e;

    typedef logic [`PERIPH_NUM_SRC-1:0] src_vec_t;  // One bit per interrupt source

endpackage

/* hw/periph_config.svh */
// ---------------------------------------------------------------------------
// Peripheral block configuration
// Bus widths, interrupt and RNG sizing, address map and LFSR constants
// ---------------------------------------------------------------------------

`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// Request bus
`define PERIPH_ADDR_W       16
`define PERIPH_DATA_W       32

// Interrupt controller
`define PERIPH_NUM_SRC      4
`define PERIPH_PRIO_W       3

// Random number FIFO
`define PERIPH_RNG_DEPTH    8
`define PERIPH_RNG_SEED     32'h1
`define PERIPH_RNG_POLY     32'h80200003      // Galois feedback taps

// Address map
`define PERIPH_ABSENT_DATA  32'hdeadbeef      // Read data of an unmapped region
`define PERIPH_REGION_LSB   12                // Region field is addr[13:12]

`endif
